/* dv/multicycle_core_golden.hex */
// word count, then the program words in address order
// trace count, then records of kind, address, value (1 retire, 2 register write, 3 store)
0000001E
4410000C 442FFFFD 40308800 40408801 40508802 40608804
40708803 40811009 40908C08 40A0900B 50B0FFEC 58C0C321
56D17FFF 14308002 38448E0A 04E08002 38F48E02 4CE18002
45000001 4CE1C002 4C110002 4C114002 45000001 48000003
7D08C123 48000003 48FFFFFE 45000001 41119000 48000000
0000002D
1 00000000 00000000 2 00000001 0000000C
1 00000004 00000000 2 00000002 FFFFFFFD
1 00000008 00000000 2 00000003 00000009
1 0000000C 00000000 2 00000004 0000000F
1 00000010 00000000 2 00000005 0000000C
1 00000014 00000000 2 00000006 FFFFFFFD
1 00000018 00000000 2 00000007 FFFFFFF1
1 0000001C 00000000 2 00000008 0FFFFFFF
1 00000020 00000000 2 00000009 00000060
1 00000024 00000000 2 0000000A C0000000
1 00000028 00000000 2 0000000B FFFFFFF8
1 0000002C 00000000 2 0000000C 0000432D
1 00000030 00000000 2 0000000D FFFF8002
// stores land one cycle ahead of their retire
3 00000014 00000009 1 00000034 00000000
3 00000084 0000000F 1 00000038 00000000
1 0000003C 00000000 2 0000000E 00000009
1 00000040 00000000 2 0000000F 0000000F
// branches, then jumps and the undefined opcode at 60
1 00000044 00000000
1 0000004C 00000000
1 00000050 00000000
1 00000054 00000000
1 0000005C 00000000
1 00000068 00000000
1 00000060 00000000
1 00000064 00000000
1 00000070 00000000 2 00000011 00000018
1 00000074 00000000

/* multicycle_core.f */
+incdir+design
design/cpu_isa_pkg.sv
design/cpu_ctrl_pkg.sv
design/alu.sv
design/register_file.sv
design/controller.sv
design/datapath.sv
design/memory_system.sv
design/multicycle_core.sv
dv/retire_checker.sv
dv/tb_multicycle_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_multicycle_core
FILELIST  ?= multicycle_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	$(SIM) | tee $(LOG)
	@if grep -q "test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "test passed" $(LOG) || { echo "no pass message in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/tb_multicycle_core.sv */
`include "cpu_cfg.svh"

module tb_multicycle_core;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CYCLE_LIMIT = 400;
	localparam int MIN_RESET_CYCLES = 10;

	logic                   clock;
	logic                   reset;
	logic                   load_valid;
	logic [`MEM_ADDR_W-1:0] load_addr;
	logic [31:0]            load_data;
	logic                   retire;
	logic [31:0]            retire_pc;
	logic                   reg_write;
	logic [4:0]             reg_write_addr;
	logic [31:0]            reg_write_data;
	logic                   dm_store;
	logic [31:0]            dm_store_addr;
	logic [31:0]            dm_store_data;
	logic                   trace_done;
	int                     value_errors;
	int                     event_errors;

	logic [31:0] golden [256];
	int          word_count;
	int          reset_cycles;
	int          cycles;
	logic        timed_out;

	multicycle_core u_multicycle_core (.*);

	retire_checker u_retire_checker (.*);

	always #50 clock = ~clock;

	// random address and data while the load port is idle
	task automatic drive_idle_load();
		logic [31:0] idle_addr;
		logic [31:0] idle_data;
		idle_addr = $urandom;
		idle_data = $urandom;
		load_valid = 1'b0;
		load_addr = idle_addr[`MEM_ADDR_W-1:0];
		load_data = idle_data;
	endtask

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		load_valid = 1'b0;
		load_addr = '0;
		load_data = '0;
		timed_out = 1'b0;
		void'($urandom(32'h5e73));
		$readmemh("dv/multicycle_core_golden.hex", golden);
		word_count = golden[0];
		reset_cycles = (word_count > MIN_RESET_CYCLES) ? word_count : MIN_RESET_CYCLES;

		// one program word per cycle behind reset
		for (int i = 0; i < reset_cycles; i++) begin
			@(posedge clock);
			#1;
			if (i < word_count) begin
				load_valid = 1'b1;
				load_addr = i[`MEM_ADDR_W-1:0];
				load_data = golden[i + 1];
			end else begin
				drive_idle_load();
			end
		end
		@(posedge clock);
		#1;
		drive_idle_load();
		reset = 1'b0;

		cycles = 0;
		while (!trace_done && cycles < CYCLE_LIMIT) begin
			@(posedge clock);
			#1;
			cycles++;
		end
		if (!trace_done) begin
			$display("trace did not complete within %0d cycles", CYCLE_LIMIT);
			timed_out = 1'b1;
		end

		$display("errors: %0d value, %0d event, %0d timeout",
			value_errors, event_errors, timed_out);
		if (value_errors == 0 && event_errors == 0 && !timed_out) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

/* dv/retire_checker.sv */
module retire_checker (
	input  logic        clock,
	input  logic        reset,
	input  logic        retire,
	input  logic [31:0] retire_pc,
	input  logic        reg_write,
	input  logic [4:0]  reg_write_addr,
	input  logic [31:0] reg_write_data,
	input  logic        dm_store,
	input  logic [31:0] dm_store_addr,
	input  logic [31:0] dm_store_data,
	output logic        trace_done,
	output int          value_errors,
	output int          event_errors
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [31:0] KIND_RETIRE = 32'd1;
	localparam logic [31:0] KIND_REG = 32'd2;
	localparam logic [31:0] KIND_STORE = 32'd3;

	logic [31:0] golden [256];
	int          trace_base = 0;
	int          trace_count = 0;
	int          next_record = 0;
	int          value_count = 0;
	int          event_count = 0;
	int          edge_count = 0;
	int          retire_count = 0;

	assign trace_done = (trace_count > 0) && (next_record >= trace_count);
	assign value_errors = value_count;
	assign event_errors = event_count;

	// trace count sits right after the program words
	initial begin
		$readmemh("dv/multicycle_core_golden.hex", golden);
		trace_base = golden[0] + 2;
		trace_count = golden[trace_base - 1];
	end

	function automatic logic [31:0] record_field(input int offset);
		return golden[trace_base + 3 * next_record + offset];
	endfunction

	function automatic logic [31:0] record_kind();
		if (next_record >= trace_count) begin
			return 32'd0;
		end
		return record_field(0);
	endfunction

	task automatic compare_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("** Error: %s expected %h actual %h", name, expected, actual);
			value_count++;
		end
	endtask

	// first fetch right after reset, one instruction every five cycles
	task automatic check_cycle(input string what, input int expected_cycle);
		if (edge_count != expected_cycle) begin
			$display("%s at cycle %0d after reset, expected at cycle %0d",
				what, edge_count, expected_cycle);
			event_count++;
		end
	endtask

	task automatic match_store();
		if (record_kind() == KIND_STORE) begin
			compare_value("dm_store_addr", record_field(1), dm_store_addr);
			compare_value("dm_store_data", record_field(2), dm_store_data);
			next_record++;
		end else begin
			$display("unexpected store of %h to address %h", dm_store_data, dm_store_addr);
			event_count++;
		end
	endtask

	task automatic match_retire();
		// a store that never came is still ahead of its retire
		while (record_kind() == KIND_STORE) begin
			$display("missing store to address %h", record_field(1));
			event_count++;
			next_record++;
		end
		if (record_kind() == KIND_RETIRE) begin
			compare_value("retire_pc", record_field(1), retire_pc);
			next_record++;
		end else begin
			$display("unexpected retire at pc %h", retire_pc);
			event_count++;
		end
		if (record_kind() == KIND_REG) begin
			if (reg_write === 1'b1) begin
				compare_value("reg_write_addr", record_field(1), {27'd0, reg_write_addr});
				compare_value("reg_write_data", record_field(2), reg_write_data);
			end else begin
				$display("missing register write to r%0d", record_field(1));
				event_count++;
			end
			next_record++;
		end else if (reg_write === 1'b1) begin
			$display("unexpected register write to r%0d", reg_write_addr);
			event_count++;
		end
	endtask

	always @(posedge clock) begin
		if (reset) begin
			if ((retire | reg_write | dm_store) !== 1'b0) begin
				$display("retire, register write or store seen while reset is held");
				event_count++;
			end
		end else begin
			if (dm_store === 1'b1) begin
				check_cycle("store", 5 * retire_count + 3);
				match_store();
			end
			if (retire === 1'b1) begin
				check_cycle("retire", 5 * retire_count + 4);
				retire_count++;
				match_retire();
			end else if (reg_write === 1'b1) begin
				$display("register write to r%0d without a retire", reg_write_addr);
				event_count++;
			end
			edge_count++;
		end
	end

endmodule

/* design/multicycle_core.sv */
`include "cpu_cfg.svh"

module multicycle_core (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   load_valid,
	input  logic [`MEM_ADDR_W-1:0] load_addr,
	input  logic [31:0]            load_data,
	output logic                   retire,
	output logic [31:0]            retire_pc,
	output logic                   reg_write,
	output logic [4:0]             reg_write_addr,
	output logic [31:0]            reg_write_data,
	output logic                   dm_store,
	output logic [31:0]            dm_store_addr,
	output logic [31:0]            dm_store_data
);
	import cpu_isa_pkg::*;
	import cpu_ctrl_pkg::*;

	isa_word_u              instruction;
	logic                   alu_zero;
	logic                   enable_fetch;
	logic                   enable_decode;
	logic                   enable_execute;
	logic                   enable_memaccess;
	logic                   enable_writeback;
	pc_sel_t                pc_sel;
	alu_src2_t              alu_src2_sel;
	imm_ext_t               imm_ext_sel;
	wb_sel_t                wb_sel;
	alu_op_t                alu_op;
	logic                   dm_read;
	logic                   dm_write;
	logic                   reg_write_en;
	logic [`MEM_ADDR_W-1:0] im_addr;
	logic [31:0]            im_rdata;
	logic [`MEM_ADDR_W-1:0] dm_addr;
	logic [31:0]            dm_wdata;
	logic [31:0]            dm_rdata;

	controller u_controller (.*);

	datapath u_datapath (.*);

	// the memory write strobe is the store pulse seen at the top
	memory_system u_memory_system (
		.*,
		.dm_write (dm_store)
	);

endmodule

/* design/memory_system.sv */
`include "cpu_cfg.svh"

module memory_system (
	input  logic                   clock,
	input  logic                   load_valid,
	input  logic [`MEM_ADDR_W-1:0] load_addr,
	input  logic [31:0]            load_data,
	input  logic [`MEM_ADDR_W-1:0] im_addr,
	output logic [31:0]            im_rdata,
	input  logic [`MEM_ADDR_W-1:0] dm_addr,
	input  logic [31:0]            dm_wdata,
	input  logic                   dm_write,
	output logic [31:0]            dm_rdata
);
	logic [31:0] im_mem [`MEM_WORDS];
	logic [31:0] dm_mem [`MEM_WORDS];

	initial begin
		for (int i = 0; i < `MEM_WORDS; i++) begin
			dm_mem[i] = 32'd0;
		end
	end

	// program image arrives through the load port
	always @(posedge clock) begin
		if (load_valid) begin
			im_mem[load_addr] <= load_data;
		end
		im_rdata <= im_mem[im_addr];
	end

	always @(posedge clock) begin
		if (dm_write) begin
			dm_mem[dm_addr] <= dm_wdata;
		end
		dm_rdata <= dm_mem[dm_addr];
	end

endmodule

/* design/datapath.sv */
`include "cpu_cfg.svh"

module datapath (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          enable_fetch,
	input  logic                          enable_decode,
	input  logic                          enable_execute,
	input  logic                          enable_memaccess,
	input  logic                          enable_writeback,
	input  cpu_ctrl_pkg::pc_sel_t         pc_sel,
	input  cpu_ctrl_pkg::alu_src2_t       alu_src2_sel,
	input  cpu_ctrl_pkg::imm_ext_t        imm_ext_sel,
	input  cpu_ctrl_pkg::wb_sel_t         wb_sel,
	input  cpu_ctrl_pkg::alu_op_t         alu_op,
	input  logic                          dm_read,
	input  logic                          dm_write,
	input  logic                          reg_write_en,
	output cpu_isa_pkg::isa_word_u        instruction,
	output logic                          alu_zero,
	output logic [`MEM_ADDR_W-1:0]        im_addr,
	input  logic [31:0]                   im_rdata,
	output logic [`MEM_ADDR_W-1:0]        dm_addr,
	output logic [31:0]                   dm_wdata,
	input  logic [31:0]                   dm_rdata,
	output logic                          retire,
	output logic [31:0]                   retire_pc,
	output logic                          reg_write,
	output logic [4:0]                    reg_write_addr,
	output logic [31:0]                   reg_write_data,
	output logic                          dm_store,
	output logic [31:0]                   dm_store_addr,
	output logic [31:0]                   dm_store_data
);
	import cpu_ctrl_pkg::*;

	logic [31:0] pc;
	logic [31:0] ir_bits;
	logic [31:0] ra_data;
	logic [31:0] rb_data;
	logic [31:0] rt_data;
	logic [31:0] imm_ext;
	logic [31:0] alu_b;
	logic [31:0] alu_result;
	logic        alu_zero_raw;
	logic [31:0] alu_result_q;
	logic [31:0] rt_q;
	logic [31:0] wb_data;
	logic [31:0] pc_next;

	assign ir_bits = instruction;

	register_file u_register_file (
		.clock      (clock),
		.reset      (reset),
		.ra_addr    (instruction.r.ra),
		.rb_addr    (instruction.r.rb),
		.rt_addr    (instruction.r.rt),
		.ra_data    (ra_data),
		.rb_data    (rb_data),
		.rt_data    (rt_data),
		.write_en   (reg_write),
		.write_addr (instruction.r.rt),
		.write_data (wb_data)
	);

	alu u_alu (
		.a      (ra_data),
		.b      (alu_b),
		.op     (alu_op),
		.result (alu_result),
		.zero   (alu_zero_raw)
	);

	always_comb begin
		case (imm_ext_sel)
			IMM5_ZE:  imm_ext = {27'd0, instruction.r.rb};
			IMM15_SE: imm_ext = {{17{instruction.i.imm[14]}}, instruction.i.imm};
			IMM20_SE: imm_ext = {{12{ir_bits[19]}}, ir_bits[19:0]};
			default:  imm_ext = {17'd0, instruction.i.imm};
		endcase
	end

	always_comb begin
		case (alu_src2_sel)
			RB_DATA: alu_b = rb_data;
			IMM:     alu_b = imm_ext;
			LSWI:    alu_b = {15'd0, instruction.i.imm, 2'b00};
			LSW:     alu_b = rb_data << instruction.r.sv;
			BENX:    alu_b = rt_data;
			default: alu_b = 32'd0;
		endcase
	end

	always_comb begin
		case (wb_sel)
			ALU_RESULT: wb_data = alu_result_q;
			IMM_DATA:   wb_data = imm_ext;
			LOAD_DATA:  wb_data = dm_rdata;
			default:    wb_data = 32'd0;
		endcase
	end

	// branch and jump offsets are word counts
	always_comb begin
		case (pc_sel)
			PC_BRANCH: pc_next = pc + {{16{ir_bits[13]}}, ir_bits[13:0], 2'b00};
			PC_JUMP:   pc_next = pc + {{6{ir_bits[23]}}, ir_bits[23:0], 2'b00};
			default:   pc_next = pc + 32'd4;
		endcase
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			pc <= `RESET_PC;
			instruction <= '0;
		end else begin
			if (enable_decode) begin
				instruction <= im_rdata;
			end
			if (enable_writeback) begin
				pc <= pc_next;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (enable_execute) begin
			alu_result_q <= alu_result;
			alu_zero <= alu_zero_raw;
			rt_q <= rt_data;
		end
	end

	// memory addresses park at zero when idle
	assign im_addr = enable_fetch ? pc[`MEM_ADDR_W+1:2] : '0;
	assign dm_addr = (dm_read | dm_write) ? alu_result_q[`MEM_ADDR_W+1:2] : '0;
	assign dm_wdata = rt_q;

	assign retire = enable_writeback;
	assign retire_pc = pc;
	assign reg_write = reg_write_en & enable_writeback;
	assign reg_write_addr = instruction.r.rt;
	assign reg_write_data = wb_data;
	assign dm_store = dm_write & enable_memaccess;
	assign dm_store_addr = alu_result_q;
	assign dm_store_data = rt_q;

endmodule

/* design/controller.sv */
module controller (
	input  logic                    clock,
	input  logic                    reset,
	input  cpu_isa_pkg::isa_word_u  instruction,
	input  logic                    alu_zero,
	output logic                    enable_fetch,
	output logic                    enable_decode,
	output logic                    enable_execute,
	output logic                    enable_memaccess,
	output logic                    enable_writeback,
	output cpu_ctrl_pkg::pc_sel_t   pc_sel,
	output cpu_ctrl_pkg::alu_src2_t alu_src2_sel,
	output cpu_ctrl_pkg::imm_ext_t  imm_ext_sel,
	output cpu_ctrl_pkg::wb_sel_t   wb_sel,
	output cpu_ctrl_pkg::alu_op_t   alu_op,
	output logic                    dm_read,
	output logic                    dm_write,
	output logic                    reg_write_en
);
	import cpu_isa_pkg::*;
	import cpu_ctrl_pkg::*;

	ctrl_state_t state;
	ctrl_state_t next_state;
	sub_base_t   sub_base;
	sub_ls_t     sub_ls;

	assign sub_base = sub_base_t'(instruction.r.sub[4:0]);
	assign sub_ls = sub_ls_t'(instruction.r.sub);

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= FETCH;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		case (state)
			FETCH:     next_state = DECODE;
			DECODE:    next_state = EXECUTE;
			EXECUTE:   next_state = MEMACCESS;
			MEMACCESS: next_state = WRITEBACK;
			default:   next_state = FETCH;
		endcase
	end

	assign enable_fetch = (state == FETCH);
	assign enable_decode = (state == DECODE);
	assign enable_execute = (state == EXECUTE);
	assign enable_memaccess = (state == MEMACCESS);
	assign enable_writeback = (state == WRITEBACK);

	// taken when the sense bit and the equal flag disagree
	always_comb begin
		case (instruction.r.opcode)
			TY_B:    pc_sel = (instruction.i.imm[14] ^ alu_zero) ? PC_BRANCH : PC_PLUS4;
			JJ:      pc_sel = PC_JUMP;
			default: pc_sel = PC_PLUS4;
		endcase
	end

	always_comb begin
		alu_src2_sel = SRC2_NONE;
		imm_ext_sel = IMM15_ZE;
		wb_sel = WB_NONE;
		alu_op = cpu_ctrl_pkg::ADD;
		dm_read = 1'b0;
		dm_write = 1'b0;
		reg_write_en = 1'b0;
		case (instruction.r.opcode)
			TY_BASE: begin
				case (sub_base)
					cpu_isa_pkg::ADD, cpu_isa_pkg::SUB, cpu_isa_pkg::AND,
					cpu_isa_pkg::OR, cpu_isa_pkg::XOR: begin
						alu_src2_sel = RB_DATA;
						wb_sel = ALU_RESULT;
						reg_write_en = 1'b1;
					end
					SRLI, SLLI, ROTRI: begin
						alu_src2_sel = IMM;
						imm_ext_sel = IMM5_ZE;
						wb_sel = ALU_RESULT;
						reg_write_en = 1'b1;
					end
					default: ;
				endcase
				case (sub_base)
					cpu_isa_pkg::SUB: alu_op = cpu_ctrl_pkg::SUB;
					cpu_isa_pkg::AND: alu_op = cpu_ctrl_pkg::AND;
					cpu_isa_pkg::OR:  alu_op = cpu_ctrl_pkg::OR;
					cpu_isa_pkg::XOR: alu_op = cpu_ctrl_pkg::XOR;
					SRLI:             alu_op = SRL;
					SLLI:             alu_op = SLL;
					ROTRI:            alu_op = ROR;
					default:          alu_op = cpu_ctrl_pkg::ADD;
				endcase
			end
			ADDI, ORI, XORI: begin
				alu_src2_sel = IMM;
				wb_sel = ALU_RESULT;
				reg_write_en = 1'b1;
				if (instruction.r.opcode == ADDI) begin
					imm_ext_sel = IMM15_SE;
				end else if (instruction.r.opcode == ORI) begin
					alu_op = cpu_ctrl_pkg::OR;
				end else begin
					alu_op = cpu_ctrl_pkg::XOR;
				end
			end
			MOVI: begin
				alu_src2_sel = IMM;
				imm_ext_sel = IMM20_SE;
				wb_sel = IMM_DATA;
				reg_write_en = 1'b1;
			end
			LWI: begin
				alu_src2_sel = LSWI;
				wb_sel = LOAD_DATA;
				dm_read = 1'b1;
				reg_write_en = 1'b1;
			end
			SWI: begin
				alu_src2_sel = LSWI;
				dm_write = 1'b1;
			end
			TY_LS: begin
				if (sub_ls == LW) begin
					alu_src2_sel = LSW;
					wb_sel = LOAD_DATA;
					dm_read = 1'b1;
					reg_write_en = 1'b1;
				end else if (sub_ls == SW) begin
					alu_src2_sel = LSW;
					dm_write = 1'b1;
				end
			end
			// ra minus rt sets the zero flag for the branch
			TY_B: begin
				alu_src2_sel = BENX;
				alu_op = cpu_ctrl_pkg::SUB;
			end
			default: ;
		endcase
	end

endmodule

/* design/register_file.sv */
module register_file (
	input  logic        clock,
	input  logic        reset,
	input  logic [4:0]  ra_addr,
	input  logic [4:0]  rb_addr,
	input  logic [4:0]  rt_addr,
	output logic [31:0] ra_data,
	output logic [31:0] rb_data,
	output logic [31:0] rt_data,
	input  logic        write_en,
	input  logic [4:0]  write_addr,
	input  logic [31:0] write_data
);
	logic [31:0] regs [32];

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= 32'd0;
			end
		end else if (write_en) begin
			regs[write_addr] <= write_data;
		end
	end

	// rt port feeds store data and branch compare
	assign ra_data = regs[ra_addr];
	assign rb_data = regs[rb_addr];
	assign rt_data = regs[rt_addr];

endmodule

/* design/alu.sv */
module alu (
	input  logic                  [31:0] a,
	input  logic                  [31:0] b,
	input  cpu_ctrl_pkg::alu_op_t        op,
	output logic                  [31:0] result,
	output logic                         zero
);
	import cpu_ctrl_pkg::*;

	logic [4:0]  shamt;
	logic [63:0] rotated;

	assign shamt = b[4:0];
	// low half of the doubled word gives the right rotate
	assign rotated = {a, a} >> shamt;

	always_comb begin
		case (op)
			SUB:     result = a - b;
			AND:     result = a & b;
			OR:      result = a | b;
			XOR:     result = a ^ b;
			SRL:     result = a >> shamt;
			SLL:     result = a << shamt;
			ROR:     result = rotated[31:0];
			default: result = a + b;
		endcase
	end

	assign zero = (result == 32'd0);

endmodule

/* design/cpu_ctrl_pkg.sv */
package cpu_ctrl_pkg;

	typedef enum logic [2:0] {
		FETCH,
		DECODE,
		EXECUTE,
		MEMACCESS,
		WRITEBACK
	} ctrl_state_t;

	typedef enum logic [1:0] {PC_PLUS4, PC_BRANCH, PC_JUMP} pc_sel_t;

	// LSWI is imm << 2, LSW is rb << sv, BENX is rt for compare
	typedef enum logic [2:0] {RB_DATA, IMM, LSWI, LSW, BENX, SRC2_NONE} alu_src2_t;

	typedef enum logic [1:0] {IMM5_ZE, IMM15_ZE, IMM15_SE, IMM20_SE} imm_ext_t;

	typedef enum logic [1:0] {ALU_RESULT, IMM_DATA, LOAD_DATA, WB_NONE} wb_sel_t;

	typedef enum logic [2:0] {ADD, SUB, AND, OR, XOR, SRL, SLL, ROR} alu_op_t;

endpackage

/* design/cpu_isa_pkg.sv */
package cpu_isa_pkg;

	typedef enum logic [5:0] {
		LWI     = 6'b000010,
		SWI     = 6'b001010,
		TY_LS   = 6'b011100,
		TY_BASE = 6'b100000,
		MOVI    = 6'b100010,
		JJ      = 6'b100100,
		TY_B    = 6'b100110,
		ADDI    = 6'b101000,
		XORI    = 6'b101011,
		ORI     = 6'b101100
	} opcode_t;

	// low 5 bits of the sub-opcode field
	typedef enum logic [4:0] {
		ADD   = 5'b00000,
		SUB   = 5'b00001,
		AND   = 5'b00010,
		XOR   = 5'b00011,
		OR    = 5'b00100,
		SLLI  = 5'b01000,
		SRLI  = 5'b01001,
		ROTRI = 5'b01011
	} sub_base_t;

	typedef enum logic [7:0] {
		LW = 8'b00000010,
		SW = 8'b00001010
	} sub_ls_t;

	typedef struct packed {
		logic       rsv;
		opcode_t    opcode;
		logic [4:0] rt;
		logic [4:0] ra;
		logic [4:0] rb;
		logic [1:0] sv;
		logic [7:0] sub;
	} reg_view_t;

	// imm[14] doubles as the branch sense, 0 is BEQ
	typedef struct packed {
		logic        rsv;
		opcode_t     opcode;
		logic [4:0]  rt;
		logic [4:0]  ra;
		logic [14:0] imm;
	} imm_view_t;

	typedef union packed {
		reg_view_t r;
		imm_view_t i;
	} isa_word_u;

endpackage

/* design/cpu_cfg.svh */
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// same depth for instruction and data memory
`define MEM_WORDS 1024
`define MEM_ADDR_W 10

`define RESET_PC 32'h0000_0000

`endif
